// File: hw/lsu_pkg.sv
package lsu_pkg;

	localparam int addr_width       = 32;
	localparam int line_width       = 64;
	localparam int strb_width       = 8;
	localparam int line_offset_bits = 3;
	localparam int id_width         = 4;
	localparam int reg_addr_width   = 5;

	typedef enum logic [3:0] {
		op_lb  = 4'd0,
		op_lbu = 4'd1,
		op_lh  = 4'd2,
		op_lhu = 4'd3,
		op_lw  = 4'd4,
		op_sb  = 4'd5,
		op_sh  = 4'd6,
		op_sw  = 4'd7
	} mem_op_e;

	typedef enum logic [2:0] {
		rd_idle,
		rd_wait_arready,
		rd_wait_rvalid,
		rd_done,
		rd_second
	} read_state_e;

	typedef enum logic [2:0] {
		wr_idle,
		wr_wait_awready,
		wr_wait_wready,
		wr_wait_bvalid,
		wr_done,
		wr_second
	} write_state_e;

	function automatic logic is_load(mem_op_e op);
		return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
	endfunction

	// access width in bytes: 1, 2 or 4
	function automatic logic [2:0] access_bytes(mem_op_e op);
		case (op)
			op_lb, op_lbu, op_sb: return 3'd1;
			op_lh, op_lhu, op_sh: return 3'd2;
			default: return 3'd4;
		endcase
	endfunction

endpackage

// File: hw/store_align.sv
module store_align (
	input  lsu_pkg::mem_op_e                     op,
	input  logic [lsu_pkg::line_offset_bits-1:0] byte_offset,
	input  logic [lsu_pkg::addr_width-1:0]       store_data,
	input  logic                                 second_beat,
	output logic [lsu_pkg::line_width-1:0]       beat_data,
	output logic [lsu_pkg::strb_width-1:0]       beat_strb
);

	logic [lsu_pkg::line_width-1:0]   data_wide;
	logic [2*lsu_pkg::line_width-1:0] data_rot;
	logic [2*lsu_pkg::strb_width-1:0] byte_mask;
	logic [2*lsu_pkg::strb_width-1:0] strb_span;

	assign data_wide = {{(lsu_pkg::line_width-lsu_pkg::addr_width){1'b0}}, store_data};

	// rotate left by offset bytes, upper half of the doubled copy
	assign data_rot  = {data_wide, data_wide} << {byte_offset, 3'b000};
	assign beat_data = data_rot[2*lsu_pkg::line_width-1:lsu_pkg::line_width];

	always_comb begin
		case (lsu_pkg::access_bytes(op))
			3'd1: byte_mask = 16'h0001;
			3'd2: byte_mask = 16'h0003;
			default: byte_mask = 16'h000f;
		endcase
	end

	// low half covers this line, high half spills into the next
	assign strb_span = byte_mask << byte_offset;
	assign beat_strb = second_beat ? strb_span[2*lsu_pkg::strb_width-1:lsu_pkg::strb_width]
		: strb_span[lsu_pkg::strb_width-1:0];

endmodule

// File: hw/load_extract.sv
module load_extract (
	input  lsu_pkg::mem_op_e                     op,
	input  logic [lsu_pkg::line_offset_bits-1:0] byte_offset,
	input  logic [lsu_pkg::line_width-1:0]       first_beat,
	input  logic [lsu_pkg::line_width-1:0]       rdata,
	input  logic                                 split,
	output logic [lsu_pkg::addr_width-1:0]       load_value
);

	logic [2*lsu_pkg::line_width-1:0] window;
	logic [2*lsu_pkg::line_width-1:0] window_shift;
	logic [lsu_pkg::addr_width-1:0]   raw;

	// split access: earlier line in the low half, current beat above it
	assign window = split ? {rdata, first_beat}
		: {{lsu_pkg::line_width{1'b0}}, rdata};

	assign window_shift = window >> {byte_offset, 3'b000};
	assign raw          = window_shift[lsu_pkg::addr_width-1:0];

	always_comb begin
		case (op)
			lsu_pkg::op_lb:  load_value = {{24{raw[7]}}, raw[7:0]};
			lsu_pkg::op_lbu: load_value = {24'd0, raw[7:0]};
			lsu_pkg::op_lh:  load_value = {{16{raw[15]}}, raw[15:0]};
			lsu_pkg::op_lhu: load_value = {16'd0, raw[15:0]};
			default:         load_value = raw;
		endcase
	end

endmodule

// File: hw/axi_read_ctrl.sv
module axi_read_ctrl (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  logic                            need_second,
	input  logic [lsu_pkg::addr_width-1:0]  line_addr,
	input  logic [lsu_pkg::id_width-1:0]    id,
	output logic                            arvalid,
	input  logic                            arready,
	output logic [lsu_pkg::addr_width-1:0]  araddr,
	output logic [lsu_pkg::id_width-1:0]    arid,
	input  logic                            rvalid,
	output logic                            rready,
	input  logic [lsu_pkg::line_width-1:0]  rdata,
	input  logic [lsu_pkg::id_width-1:0]    rid,
	output logic [lsu_pkg::line_width-1:0]  first_beat,
	output logic                            second_beat,
	output logic                            done
);

	lsu_pkg::read_state_e state;
	logic                 r_accept;
	logic                 last_beat;

	// a response only counts with a matching id
	assign r_accept  = rvalid && rready && (rid == arid);
	assign last_beat = !need_second || second_beat;
	assign done      = r_accept && last_beat;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= lsu_pkg::rd_idle;
			arvalid     <= 1'b0;
			rready      <= 1'b0;
			second_beat <= 1'b0;
		end else begin
			case (state)
				lsu_pkg::rd_idle: begin
					if (start) begin
						arvalid <= 1'b1;
						state   <= lsu_pkg::rd_wait_arready;
					end
				end
				lsu_pkg::rd_wait_arready: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= lsu_pkg::rd_wait_rvalid;
					end
				end
				lsu_pkg::rd_wait_rvalid: begin
					if (r_accept) begin
						rready <= 1'b0;
						if (last_beat) begin
							second_beat <= 1'b0;
							state       <= lsu_pkg::rd_done;
						end else begin
							second_beat <= 1'b1;
							state       <= lsu_pkg::rd_second;
						end
					end
				end
				// slot refills here, wait one cycle before looking at start
				lsu_pkg::rd_done: state <= lsu_pkg::rd_idle;
				lsu_pkg::rd_second: begin
					arvalid <= 1'b1;
					state   <= lsu_pkg::rd_wait_arready;
				end
				default: state <= lsu_pkg::rd_idle;
			endcase
		end
	end

	// address and id sampled when the request goes out
	always_ff @(posedge clock) begin
		if (state == lsu_pkg::rd_idle && start) begin
			araddr <= line_addr;
			arid   <= id;
		end else if (state == lsu_pkg::rd_second) begin
			araddr <= line_addr + lsu_pkg::strb_width;
			arid   <= id;
		end
	end

	always_ff @(posedge clock) begin
		if (r_accept && !last_beat) begin
			first_beat <= rdata;
		end
	end

endmodule

// File: hw/axi_write_ctrl.sv
module axi_write_ctrl (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  logic                            need_second,
	input  logic [lsu_pkg::addr_width-1:0]  line_addr,
	input  logic [lsu_pkg::id_width-1:0]    id,
	input  logic [lsu_pkg::line_width-1:0]  beat_data,
	input  logic [lsu_pkg::strb_width-1:0]  beat_strb,
	output logic                            awvalid,
	input  logic                            awready,
	output logic [lsu_pkg::addr_width-1:0]  awaddr,
	output logic [lsu_pkg::id_width-1:0]    awid,
	output logic                            wvalid,
	input  logic                            wready,
	output logic [lsu_pkg::line_width-1:0]  wdata,
	output logic [lsu_pkg::strb_width-1:0]  wstrb,
	input  logic                            bvalid,
	output logic                            bready,
	input  logic [lsu_pkg::id_width-1:0]    bid,
	output logic                            second_beat,
	output logic                            done
);

	lsu_pkg::write_state_e state;
	logic                  b_accept;
	logic                  last_beat;

	assign b_accept  = bvalid && bready && (bid == awid);
	assign last_beat = !need_second || second_beat;
	assign done      = b_accept && last_beat;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= lsu_pkg::wr_idle;
			awvalid     <= 1'b0;
			wvalid      <= 1'b0;
			bready      <= 1'b0;
			second_beat <= 1'b0;
		end else begin
			case (state)
				lsu_pkg::wr_idle: begin
					if (start) begin
						awvalid <= 1'b1;
						state   <= lsu_pkg::wr_wait_awready;
					end
				end
				// data phase opens only after the address handshake
				lsu_pkg::wr_wait_awready: begin
					if (awready) begin
						awvalid <= 1'b0;
						wvalid  <= 1'b1;
						state   <= lsu_pkg::wr_wait_wready;
					end
				end
				lsu_pkg::wr_wait_wready: begin
					if (wready) begin
						wvalid <= 1'b0;
						bready <= 1'b1;
						state  <= lsu_pkg::wr_wait_bvalid;
					end
				end
				lsu_pkg::wr_wait_bvalid: begin
					if (b_accept) begin
						bready <= 1'b0;
						if (last_beat) begin
							second_beat <= 1'b0;
							state       <= lsu_pkg::wr_done;
						end else begin
							second_beat <= 1'b1;
							state       <= lsu_pkg::wr_second;
						end
					end
				end
				lsu_pkg::wr_done: state <= lsu_pkg::wr_idle;
				lsu_pkg::wr_second: begin
					awvalid <= 1'b1;
					state   <= lsu_pkg::wr_wait_awready;
				end
				default: state <= lsu_pkg::wr_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == lsu_pkg::wr_idle && start) begin
			awaddr <= line_addr;
			awid   <= id;
		end else if (state == lsu_pkg::wr_second) begin
			awaddr <= line_addr + lsu_pkg::strb_width;
			awid   <= id;
		end
	end

	// beat payload held steady for the whole data phase
	always_ff @(posedge clock) begin
		if (state == lsu_pkg::wr_wait_awready && awready) begin
			wdata <= beat_data;
			wstrb <= beat_strb;
		end
	end

endmodule

// File: hw/mem_stage.sv
module mem_stage (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                in_valid,
	input  lsu_pkg::mem_op_e                    in_op,
	input  logic [lsu_pkg::addr_width-1:0]      in_base,
	input  logic [lsu_pkg::addr_width-1:0]      in_offset,
	input  logic [lsu_pkg::addr_width-1:0]      in_store_data,
	input  logic [lsu_pkg::reg_addr_width-1:0]  in_rd,
	output logic                                allowin,
	output logic                                arvalid,
	input  logic                                arready,
	output logic [lsu_pkg::addr_width-1:0]      araddr,
	output logic [lsu_pkg::id_width-1:0]        arid,
	input  logic                                rvalid,
	output logic                                rready,
	input  logic [lsu_pkg::line_width-1:0]      rdata,
	input  logic [lsu_pkg::id_width-1:0]        rid,
	output logic                                awvalid,
	input  logic                                awready,
	output logic [lsu_pkg::addr_width-1:0]      awaddr,
	output logic [lsu_pkg::id_width-1:0]        awid,
	output logic                                wvalid,
	input  logic                                wready,
	output logic [lsu_pkg::line_width-1:0]      wdata,
	output logic [lsu_pkg::strb_width-1:0]      wstrb,
	input  logic                                bvalid,
	output logic                                bready,
	input  logic [lsu_pkg::id_width-1:0]        bid,
	output logic                                wb_valid,
	output logic                                wb_wen,
	output logic [lsu_pkg::reg_addr_width-1:0]  wb_rd,
	output logic [lsu_pkg::addr_width-1:0]      wb_data
);

	logic                                   slot_valid;
	lsu_pkg::mem_op_e                       slot_op;
	logic [lsu_pkg::addr_width-1:0]         slot_base;
	logic [lsu_pkg::addr_width-1:0]         slot_offset;
	logic [lsu_pkg::addr_width-1:0]         slot_store_data;
	logic [lsu_pkg::reg_addr_width-1:0]     slot_rd;
	logic [lsu_pkg::id_width-1:0]           id_count;
	logic [lsu_pkg::addr_width-1:0]         eff_addr;
	logic [lsu_pkg::addr_width-1:0]         line_addr;
	logic [lsu_pkg::line_offset_bits-1:0]   byte_offset;
	logic                                   need_second;
	logic                                   slot_is_load;
	logic                                   rd_done;
	logic                                   wr_done;
	logic                                   ready_go;
	logic                                   rd_second_beat;
	logic                                   wr_second_beat;
	logic [lsu_pkg::line_width-1:0]         first_beat;
	logic [lsu_pkg::line_width-1:0]         beat_data;
	logic [lsu_pkg::strb_width-1:0]         beat_strb;
	logic [lsu_pkg::addr_width-1:0]         load_value;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_valid <= 1'b0;
		end else if (allowin) begin
			slot_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && allowin) begin
			slot_op         <= in_op;
			slot_base       <= in_base;
			slot_offset     <= in_offset;
			slot_store_data <= in_store_data;
			slot_rd         <= in_rd;
		end
	end

	// transaction id source, wraps freely
	always_ff @(posedge clock) begin
		if (reset) begin
			id_count <= '0;
		end else begin
			id_count <= id_count + 1'b1;
		end
	end

	assign eff_addr     = slot_base + slot_offset;
	assign byte_offset  = eff_addr[lsu_pkg::line_offset_bits-1:0];
	assign line_addr    = {eff_addr[lsu_pkg::addr_width-1:lsu_pkg::line_offset_bits],
		{lsu_pkg::line_offset_bits{1'b0}}};
	assign slot_is_load = lsu_pkg::is_load(slot_op);

	// access runs past the end of the 8-byte line
	assign need_second = ({1'b0, byte_offset} + {1'b0, lsu_pkg::access_bytes(slot_op)}) > 4'd8;

	assign ready_go = slot_is_load ? rd_done : wr_done;
	assign allowin  = !slot_valid || ready_go;

	assign wb_valid = slot_valid && ready_go;
	assign wb_wen   = wb_valid && slot_is_load;
	assign wb_rd    = slot_rd;
	assign wb_data  = load_value;

	axi_read_ctrl read_ctrl0 (
		.clock       (clock),
		.reset       (reset),
		.start       (slot_valid && slot_is_load),
		.need_second (need_second),
		.line_addr   (line_addr),
		.id          (id_count),
		.arvalid     (arvalid),
		.arready     (arready),
		.araddr      (araddr),
		.arid        (arid),
		.rvalid      (rvalid),
		.rready      (rready),
		.rdata       (rdata),
		.rid         (rid),
		.first_beat  (first_beat),
		.second_beat (rd_second_beat),
		.done        (rd_done)
	);

	axi_write_ctrl write_ctrl0 (
		.clock       (clock),
		.reset       (reset),
		.start       (slot_valid && !slot_is_load),
		.need_second (need_second),
		.line_addr   (line_addr),
		.id          (id_count),
		.beat_data   (beat_data),
		.beat_strb   (beat_strb),
		.awvalid     (awvalid),
		.awready     (awready),
		.awaddr      (awaddr),
		.awid        (awid),
		.wvalid      (wvalid),
		.wready      (wready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.bvalid      (bvalid),
		.bready      (bready),
		.bid         (bid),
		.second_beat (wr_second_beat),
		.done        (wr_done)
	);

	store_align store_align0 (
		.op          (slot_op),
		.byte_offset (byte_offset),
		.store_data  (slot_store_data),
		.second_beat (wr_second_beat),
		.beat_data   (beat_data),
		.beat_strb   (beat_strb)
	);

	load_extract load_extract0 (
		.op          (slot_op),
		.byte_offset (byte_offset),
		.first_beat  (first_beat),
		.rdata       (rdata),
		.split       (rd_second_beat),
		.load_value  (load_value)
	);

endmodule

// File: tb/mem_stage_props.sv
module mem_stage_props (
	input logic                               clock,
	input logic                               reset,
	input logic                               arvalid,
	input logic                               arready,
	input logic [lsu_pkg::addr_width-1:0]     araddr,
	input logic [lsu_pkg::id_width-1:0]       arid,
	input logic                               rready,
	input logic                               awvalid,
	input logic                               awready,
	input logic [lsu_pkg::addr_width-1:0]     awaddr,
	input logic [lsu_pkg::id_width-1:0]       awid,
	input logic                               wvalid,
	input logic                               wready,
	input logic [lsu_pkg::line_width-1:0]     wdata,
	input logic [lsu_pkg::strb_width-1:0]     wstrb,
	input logic                               bready,
	input logic                               wb_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// request payload frozen until the memory takes it
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
		else $error("arvalid or its address changed before arready");

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
		else $error("awvalid or its address changed before awready");

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("wvalid or its data changed before wready");

	wb_pulse: assert property (@(posedge clock) disable iff (reset)
		wb_valid |=> !wb_valid)
		else $error("wb_valid held for more than one cycle");

	// one op in flight, so only one request channel is busy
	no_dual_request: assert property (@(posedge clock) disable iff (reset)
		!(arvalid && awvalid))
		else $error("arvalid and awvalid high together");

	reset_quiet: assert property (@(posedge clock)
		reset |=> !arvalid && !rready && !awvalid && !wvalid && !bready && !wb_valid)
		else $error("control output high after reset");

endmodule

// File: tb/mem_stage_tb.sv
module mem_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_ops       = 64;
	localparam int words_per_op  = 6;
	localparam int mem_lines     = 64;
	localparam int cycles_per_op = 200;

	logic        clock = 1'b0;
	logic        reset;
	logic        in_valid;
	lsu_pkg::mem_op_e in_op;
	logic [31:0] in_base;
	logic [31:0] in_offset;
	logic [31:0] in_store_data;
	logic [4:0]  in_rd;
	logic        allowin;
	logic        arvalid;
	logic        arready;
	logic [31:0] araddr;
	logic [3:0]  arid;
	logic        rvalid;
	logic        rready;
	logic [63:0] rdata;
	logic [3:0]  rid;
	logic        awvalid;
	logic        awready;
	logic [31:0] awaddr;
	logic [3:0]  awid;
	logic        wvalid;
	logic        wready;
	logic [63:0] wdata;
	logic [7:0]  wstrb;
	logic        bvalid;
	logic        bready;
	logic [3:0]  bid;
	logic        wb_valid;
	logic        wb_wen;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;

	logic [31:0] stim [0:max_ops*words_per_op-1];
	logic [63:0] mem [0:mem_lines-1];
	logic [31:0] read_addrs[$];
	logic [31:0] write_addrs[$];
	int          n_ops = 0;
	int          op_index = 0;
	int          checks = 0;
	int          errors = 0;

	always #5 clock = ~clock;

	mem_stage dut0 (
		.clock(clock), .reset(reset), .in_valid(in_valid), .in_op(in_op),
		.in_base(in_base), .in_offset(in_offset), .in_store_data(in_store_data),
		.in_rd(in_rd), .allowin(allowin),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rid(rid),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bid(bid),
		.wb_valid(wb_valid), .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	bind mem_stage mem_stage_props props0 (
		.clock(clock), .reset(reset),
		.arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid),
		.rready(rready),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bready(bready), .wb_valid(wb_valid)
	);

	function automatic bit is_store(lsu_pkg::mem_op_e op);
		return op == lsu_pkg::op_sb || op == lsu_pkg::op_sh || op == lsu_pkg::op_sw;
	endfunction

	function automatic int op_width(lsu_pkg::mem_op_e op);
		case (op)
			lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return 1;
			lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
			default: return 4;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERR %s got %h expected %h (op %0d)", name, got, expected, op_index);
		end
	endtask

	// 0 to 3 idle cycles before a ready or a response
	task automatic random_stall();
		int unsigned n;
		n = $urandom_range(3, 0);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	initial begin : fill
		for (int i = 0; i < mem_lines; i++) begin
			mem[i] = {32'(i * 8) ^ 32'h3c5a_9e17, ~(32'(i * 8) + 32'h0101_0101)};
		end
	end

	// read side of the memory, response carries the request id
	initial begin : read_port
		logic [31:0] addr;
		logic [3:0]  id;
		arready = 1'b0;
		rvalid  = 1'b0;
		rdata   = '0;
		rid     = '0;
		forever begin
			@(posedge clock);
			#1;
			if (arvalid === 1'b1) begin
				random_stall();
				arready = 1'b1;
				addr    = araddr;
				id      = arid;
				read_addrs.push_back(araddr);
				do begin
					@(posedge clock);
					#1;
				end while (arvalid);
				arready = 1'b0;
				random_stall();
				rvalid = 1'b1;
				rdata  = mem[addr[8:3]];
				rid    = id;
				do begin
					@(posedge clock);
					#1;
				end while (rready);
				rvalid = 1'b0;
			end
		end
	end

	initial begin : write_port
		logic [31:0] addr;
		logic [3:0]  id;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bid     = '0;
		forever begin
			@(posedge clock);
			#1;
			if (awvalid === 1'b1) begin
				random_stall();
				awready = 1'b1;
				addr    = awaddr;
				id      = awid;
				write_addrs.push_back(awaddr);
				do begin
					@(posedge clock);
					#1;
				end while (awvalid);
				awready = 1'b0;
				while (wvalid !== 1'b1) begin
					@(posedge clock);
					#1;
				end
				random_stall();
				wready = 1'b1;
				// per-byte write under the strobes
				for (int b = 0; b < 8; b++) begin
					if (wstrb[b]) begin
						mem[addr[8:3]][8*b +: 8] = wdata[8*b +: 8];
					end
				end
				do begin
					@(posedge clock);
					#1;
				end while (wvalid);
				wready = 1'b0;
				random_stall();
				bvalid = 1'b1;
				bid    = id;
				do begin
					@(posedge clock);
					#1;
				end while (bready);
				bvalid = 1'b0;
			end
		end
	end

	task automatic run_op(input int idx);
		lsu_pkg::mem_op_e op;
		logic [31:0] base;
		logic [31:0] offset;
		logic [31:0] expected;
		logic [31:0] addr;
		logic [31:0] line;
		logic [4:0]  rd;
		logic        accepted;
		int          beats;
		string       chan;
		logic [31:0] seen[$];
		op       = lsu_pkg::mem_op_e'(stim[idx*words_per_op][3:0]);
		base     = stim[idx*words_per_op+1];
		offset   = stim[idx*words_per_op+2];
		rd       = stim[idx*words_per_op+4][4:0];
		expected = stim[idx*words_per_op+5];
		addr     = base + offset;
		line     = {addr[31:3], 3'b000};
		// crossing the 8-byte line takes a second beat
		beats    = (int'(addr[2:0]) + op_width(op) > 8) ? 2 : 1;
		op_index = idx;
		read_addrs.delete();
		write_addrs.delete();
		in_valid      = 1'b1;
		in_op         = op;
		in_base       = base;
		in_offset     = offset;
		in_store_data = stim[idx*words_per_op+3];
		in_rd         = rd;
		do begin
			@(negedge clock);
			accepted = allowin;
			@(posedge clock);
			#1;
		end while (!accepted);
		in_valid = 1'b0;
		do begin
			@(negedge clock);
		end while (wb_valid !== 1'b1);
		check_value("wb_wen", 32'(wb_wen), is_store(op) ? 32'd0 : 32'd1);
		if (!is_store(op)) begin
			check_value("wb_rd", 32'(wb_rd), 32'(rd));
			check_value("wb_data", wb_data, expected);
		end
		@(posedge clock);
		#1;
		if (is_store(op)) begin
			chan = "awaddr";
			seen = write_addrs;
			check_value("araddr beat count", read_addrs.size(), 0);
		end else begin
			chan = "araddr";
			seen = read_addrs;
			check_value("awaddr beat count", write_addrs.size(), 0);
		end
		check_value({chan, " beat count"}, seen.size(), beats);
		if (seen.size() == beats) begin
			check_value(chan, seen[0], line);
			if (beats == 2) begin
				check_value(chan, seen[1], line + 32'd8);
			end
		end
	endtask

	initial begin : main
		void'($urandom(32'h6c5eb79d));
		reset         = 1'b1;
		in_valid      = 1'b0;
		in_op         = lsu_pkg::op_lb;
		in_base       = '0;
		in_offset     = '0;
		in_store_data = '0;
		in_rd         = '0;
		for (int i = 0; i < max_ops * words_per_op; i++) begin
			stim[i] = 32'hffff_ffff;
		end
		$readmemh("tb/mem_stage_input.txt", stim);
		while (n_ops < max_ops && stim[n_ops*words_per_op] !== 32'hffff_ffff) begin
			n_ops++;
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		if (n_ops == 0) begin
			errors++;
			$display("no operations found in the stimulus file");
		end
		for (int i = 0; i < n_ops; i++) begin
			run_op(i);
		end
		$display("%0d ops, %0d checks, %0d errors", n_ops, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// budget scales with the number of ops in the file
	initial begin : watchdog
		wait (n_ops > 0);
		repeat (n_ops * cycles_per_op) @(posedge clock);
		$display("timeout: run did not finish within %0d cycles", n_ops * cycles_per_op);
		$display("tests failed");
		$finish;
	end

endmodule

// File: mem_stage.f
hw/lsu_pkg.sv
hw/store_align.sv
hw/load_extract.sv
hw/axi_read_ctrl.sv
hw/axi_write_ctrl.sv
hw/mem_stage.sv
tb/mem_stage_props.sv
tb/mem_stage_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= mem_stage_tb
RTL_TOP    ?= mem_stage
FILELIST   ?= mem_stage.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/mem_stage_input.txt
// op base offset store_data rd expected_load (all hex, expected ignored for stores)
// op: 0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 sb, 6 sh, 7 sw
7 00000100 00000000 8badf00d 00 00000000
7 00000100 00000004 11223344 00 00000000
4 00000100 00000000 00000000 01 8badf00d
4 00000104 00000000 00000000 02 11223344
2 00000100 00000002 00000000 03 ffff8bad
3 00000100 00000002 00000000 04 00008bad
0 00000101 00000000 00000000 05 fffffff0
1 00000101 00000000 00000000 06 000000f0
0 00000100 00000007 00000000 07 00000011
7 00000120 00000005 cafebabe 00 00000000
4 00000125 00000000 00000000 08 cafebabe
7 00000130 00000006 01234567 00 00000000
4 00000136 00000000 00000000 09 01234567
7 00000140 00000007 89abcdef 00 00000000
4 00000147 00000000 00000000 0a 89abcdef
6 00000150 00000007 0000a55a 00 00000000
2 00000157 00000000 00000000 0b ffffa55a
1 00000158 00000000 00000000 0c 000000a5
7 00000180 00000000 76543210 00 00000000
5 00000180 00000001 9a9a9aee 00 00000000
7 00000180 00000004 fedcba98 00 00000000
5 00000183 00000000 12345655 00 00000000
4 00000180 00000000 00000000 0d 5554ee10
4 00000184 00000000 00000000 0e fedcba98
5 00000190 00000000 00000080 00 00000000
0 00000190 00000000 00000000 0f ffffff80
1 00000190 00000000 00000000 10 00000080
6 00000190 00000002 ffff8001 00 00000000
2 00000192 00000000 00000000 11 ffff8001
3 00000190 00000002 00000000 12 00008001
7 000001a8 fffffff8 13579bdf 00 00000000
4 000001a0 00000000 00000000 13 13579bdf
